// ==== src.f ====
rtl/memMapPkg.sv
rtl/tagInitPkg.sv
rtl/memPortIf.sv
rtl/tagInitSequencer.sv
rtl/tagBank.sv
rtl/tagReadCollector.sv
rtl/tagMemTop.sv
testbench/tagMemTb.sv

// ==== Bender.yml ====
package:
  name: tag_mem

sources:
  - files:
      - rtl/memMapPkg.sv
      - rtl/tagInitPkg.sv
      - rtl/memPortIf.sv
      - rtl/tagInitSequencer.sv
      - rtl/tagBank.sv
      - rtl/tagReadCollector.sv
      - rtl/tagMemTop.sv
  - target: test
    files:
      - testbench/tagMemTb.sv

// ==== testbench/tagMemTb.sv ====
`timescale 1ns/1ps

module tagMemTb import memMapPkg::*, tagInitPkg::*; ();

	// Port tags and sequencer timing of the tag memory
	localparam logic [4:0] HeadPortTag = 5'b01010;
	localparam logic [4:0] TailPortTag = 5'b01110;
	localparam int WalkCycles = 33;
	localparam int ReadyTimeout = 34;
	localparam int ResetCycles = 10;
	localparam int RandomReads = 300;
	localparam int ReadsAfterClear = 100;
	localparam int ClearRounds = 3;

	logic clk;
	logic arstN;
	logic clr;
	blockIdxT blockSel;
	logic ready;
	tagWordT headWord;
	tagWordT tailWord;

	// Selections in flight ordered oldest first
	blockIdxT pending[$];

	tagMemTop DUT (
		.clk(clk),
		.arstN(arstN),
		.clr(clr),
		.blockSel(blockSel),
		.ready(ready),
		.headWord(headWord),
		.tailWord(tailWord)
	);

	initial begin
		clk = 1'b0;
	end

	always #5 clk = ~clk;

	//////////////////////////////
	// Error reporting
	//////////////////////////////
	task automatic stopRun(string reason);
		$display("%s", reason);
		$display("Regression failed");
		$fatal(1, "Stopped at first error");
	endtask

	task automatic reportWordMismatch(string testName, logic [15:0] expected,
			logic [15:0] actual);
		stopRun($sformatf("** Error %s: expected %h, actual %h",
			testName, expected, actual));
	endtask

	task automatic reportCountMismatch(string testName, int expected, int actual);
		stopRun($sformatf("** Error %s: expected %0d, actual %0d",
			testName, expected, actual));
	endtask

	//////////////////////////////
	// Tag model
	//////////////////////////////
	// Block index zero-extended into the upper 11 bits above the port tag
	function automatic logic [15:0] expectedWord(int blk, logic [4:0] portTag);
		logic [15:0] word;
		word = '0;
		word[15:5] = blk[10:0];
		word[4:0] = portTag;
		return word;
	endfunction

	function automatic blockIdxT randomBlock();
		return blockIdxT'($urandom_range(NumBlocks - 1, 0));
	endfunction

	//////////////////////////////
	// Reset and ready
	//////////////////////////////
	task automatic holdReset();
		for (int i = 0; i < ResetCycles; i++) begin
			@(negedge clk);
			assert (ready === 1'b0)
				else stopRun("ready is not low while reset is asserted");
			assert (headWord === 16'h0000)
				else reportWordMismatch("reset headWord", 16'h0000, headWord);
			assert (tailWord === 16'h0000)
				else reportWordMismatch("reset tailWord", 16'h0000, tailWord);
		end
		arstN = 1'b1;
	endtask

	// Counts falling edges from the release of reset or clr until ready
	task automatic waitReady(string testName);
		int cycles;
		cycles = 0;
		while (ready !== 1'b1) begin
			@(negedge clk);
			cycles++;
			assert (cycles <= ReadyTimeout)
				else stopRun($sformatf("Timeout in %s waiting for ready", testName));
		end
		assert (cycles == WalkCycles)
			else reportCountMismatch({testName, " ready latency"}, WalkCycles, cycles);
		pending.delete();
	endtask

	//////////////////////////////
	// Read pipeline
	//////////////////////////////
	task automatic checkOldest(string testName);
		blockIdxT sel;
		logic [15:0] expHead;
		logic [15:0] expTail;
		sel = pending.pop_front();
		expHead = expectedWord(int'(sel), HeadPortTag);
		expTail = expectedWord(int'(sel), TailPortTag);
		assert (headWord === expHead)
			else reportWordMismatch($sformatf("%s head blk %0d", testName, sel),
				expHead, headWord);
		assert (tailWord === expTail)
			else reportWordMismatch($sformatf("%s tail blk %0d", testName, sel),
				expTail, tailWord);
	endtask

	// Each selection is checked two edges after it is driven
	task automatic selectBlock(blockIdxT blk, string testName);
		@(negedge clk);
		assert (ready === 1'b1)
			else stopRun($sformatf("ready dropped during reads in %s", testName));
		if (pending.size() == 2) begin
			checkOldest(testName);
		end
		blockSel = blk;
		pending.push_back(blk);
	endtask

	task automatic drainReads(string testName);
		while (pending.size() > 0) begin
			@(negedge clk);
			checkOldest(testName);
		end
	endtask

	//////////////////////////////
	// Test sequences
	//////////////////////////////
	task automatic sweepBlocks(string testName);
		for (int b = 0; b < NumBlocks; b++) begin
			selectBlock(blockIdxT'(b), testName);
		end
		drainReads(testName);
	endtask

	task automatic randomReads(int count, string testName);
		for (int i = 0; i < count; i++) begin
			selectBlock(randomBlock(), testName);
		end
		drainReads(testName);
	endtask

	// Downward sweep sees every bank change in the other direction
	task automatic reverseSweep(string testName);
		for (int b = NumBlocks - 1; b >= 0; b--) begin
			selectBlock(blockIdxT'(b), testName);
		end
		drainReads(testName);
	endtask

	task automatic clearRound(int round);
		int holdCycles;
		string testName;
		holdCycles = $urandom_range(8, 1);
		testName = $sformatf("clear round %0d", round);
		@(negedge clk);
		clr = 1'b1;
		blockSel = randomBlock();
		pending.delete();
		// Drops on the first edge that sees clr
		for (int i = 0; i < holdCycles; i++) begin
			@(negedge clk);
			assert (ready === 1'b0)
				else stopRun($sformatf("ready still high during clr in %s", testName));
			blockSel = randomBlock();
		end
		clr = 1'b0;
		waitReady(testName);
		randomReads(ReadsAfterClear, testName);
	endtask

	//////////////////////////////
	// Main sequence
	//////////////////////////////
	initial begin
		void'($urandom(32'hfcad_9f36));
		arstN = 1'b0;
		clr = 1'b0;
		blockSel = '0;

		holdReset();
		waitReady("reset walk");

		sweepBlocks("block sweep");
		reverseSweep("reverse sweep");
		randomReads(RandomReads, "random reads");

		for (int r = 0; r < ClearRounds; r++) begin
			clearRound(r);
		end

		// Same block held for several cycles
		for (int i = 0; i < 4; i++) begin
			selectBlock(blockIdxT'(NumBlocks - 1), "held selection");
		end
		drainReads("held selection");

		$display("Regression passed");
		$finish;
	end

endmodule

// ==== rtl/tagMemTop.sv ====
`timescale 1ns/1ps

module tagMemTop import memMapPkg::*, tagInitPkg::*; (
	input logic clk,
	input logic arstN,
	input logic clr,
	input blockIdxT blockSel,
	output logic ready,
	output tagWordT headWord,
	output tagWordT tailWord
);

	memPortIf port0 ();
	memPortIf port1 ();

	tagInitSequencer uSeq (
		.clk(clk),
		.arstN(arstN),
		.clr(clr),
		.blockSel(blockSel),
		.ready(ready),
		.port0(port0.master),
		.port1(port1.master)
	);

	//////////////////////////////
	// Banks
	//////////////////////////////
	for (genvar i = 0; i < NumBanks; i++) begin : gBank
		tagBank #(
			.BankId(i)
		) uBank (
			.clk(clk),
			.port0(port0.bank),
			.port1(port1.bank),
			.rData0(port0.rData[i]),
			.rData1(port1.rData[i])
		);
	end

	tagReadCollector uCollect (
		.clk(clk),
		.arstN(arstN),
		.port0(port0.monitor),
		.port1(port1.monitor),
		.rData0(port0.rData),
		.rData1(port1.rData),
		.headWord(headWord),
		.tailWord(tailWord)
	);

endmodule

// ==== rtl/tagReadCollector.sv ====
`timescale 1ns/1ps

module tagReadCollector import memMapPkg::*, tagInitPkg::*; (
	input logic clk,
	input logic arstN,
	memPortIf.monitor port0,
	memPortIf.monitor port1,
	input tagWordT rData0 [NumBanks],
	input tagWordT rData1 [NumBanks],
	output tagWordT headWord,
	output tagWordT tailWord
);

	bankIdxT bank0Q;
	bankIdxT bank1Q;

	//////////////////////////////
	// Bank select and output regs
	//////////////////////////////
	// Bank index delayed to match the bank read latency
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			bank0Q <= '0;
			bank1Q <= '0;
		end else begin
			bank0Q <= bankOf(port0.addr);
			bank1Q <= bankOf(port1.addr);
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			headWord <= '0;
			tailWord <= '0;
		end else begin
			headWord <= rData0[bank0Q];
			tailWord <= rData1[bank1Q];
		end
	end

	// Head and tail of a block always sit in the same bank
	sameBank: assert property (@(posedge clk) disable iff (!arstN)
		!$isunknown({bank0Q, bank1Q}) |-> bank0Q == bank1Q)
		else $error("Head bank %0d and tail bank %0d differ", bank0Q, bank1Q);

endmodule

// ==== rtl/tagBank.sv ====
`timescale 1ns/1ps

module tagBank import memMapPkg::*, tagInitPkg::*; #(
	parameter int BankId = 0
) (
	input logic clk,
	memPortIf.bank port0,
	memPortIf.bank port1,
	output tagWordT rData0,
	output tagWordT rData1
);

	localparam int Depth = BlocksPerBank * BlockWords;

	tagWordT mem [Depth];

	logic [BankAddrWidth-1:0] local0;
	logic [BankAddrWidth-1:0] local1;
	logic hit0;
	logic hit1;

	//////////////////////////////
	// Bank decode
	//////////////////////////////
	assign local0 = bankOffset(port0.addr);
	assign local1 = bankOffset(port1.addr);

	// Only addresses inside this bank are written
	assign hit0 = port0.we && (bankOf(port0.addr) == bankIdxT'(BankId));
	assign hit1 = port1.we && (bankOf(port1.addr) == bankIdxT'(BankId));

	//////////////////////////////
	// Storage
	//////////////////////////////
	always_ff @(posedge clk) begin
		if (hit0) begin
			mem[local0] <= port0.wdata;
		end
		if (hit1) begin
			mem[local1] <= port1.wdata;
		end
	end

	// Both read ports registered every cycle
	always_ff @(posedge clk) begin
		rData0 <= mem[local0];
		rData1 <= mem[local1];
	end

	noLocalCollision: assert property (@(posedge clk)
		!(hit0 && hit1 && local0 == local1))
		else $error("Bank %0d double write at %h", BankId, local0);

endmodule

// ==== rtl/tagInitSequencer.sv ====
`timescale 1ns/1ps

module tagInitSequencer import memMapPkg::*, tagInitPkg::*; (
	input logic clk,
	input logic arstN,
	input logic clr,
	input blockIdxT blockSel,
	output logic ready,
	memPortIf.master port0,
	memPortIf.master port1
);

	seqStateT state;
	blockIdxT blockCnt;
	blockIdxT curBlock;

	//////////////////////////////
	// State and block counter
	//////////////////////////////
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			state <= SeqIdle;
			blockCnt <= '0;
		end else if (clr) begin
			state <= SeqIdle;
			blockCnt <= '0;
		end else begin
			case (state)
				SeqIdle: begin
					state <= SeqWriting;
				end
				SeqWriting: begin
					blockCnt <= blockCnt + 1'b1;
					// Park once the last block is written
					if (blockCnt == blockIdxT'(NumBlocks - 1)) begin
						state <= SeqParked;
					end
				end
				SeqParked: begin
					state <= SeqParked;
				end
				default: begin
					state <= SeqIdle;
				end
			endcase
		end
	end

	//////////////////////////////
	// Port drive
	//////////////////////////////
	// Counter while walking and external selection once parked
	assign curBlock = (state == SeqParked) ? blockSel : blockCnt;

	always_comb begin
		port0.addr = headAddr(curBlock);
		port1.addr = tailAddr(curBlock);
		port0.we = (state == SeqWriting);
		port1.we = (state == SeqWriting);
		port0.wdata = makeTag(IdxFieldWidth'(curBlock), HeadTag);
		port1.wdata = makeTag(IdxFieldWidth'(curBlock), TailTag);
	end

	assign ready = (state == SeqParked);

	// Head and tail of one block never collide
	noSameAddrWrite: assert property (@(posedge clk) disable iff (!arstN)
		!(port0.we && port1.we && port0.addr == port1.addr))
		else $error("Both ports write address %h", port0.addr);

	// Walk covers every block before ready
	readyAfterWalk: assert property (@(posedge clk) disable iff (!arstN || clr)
		(state == SeqWriting && blockCnt == '0) |-> ##NumBlocks ready)
		else $error("ready not raised after full walk");

endmodule

// ==== rtl/memPortIf.sv ====
`timescale 1ns/1ps

interface memPortIf import memMapPkg::*, tagInitPkg::*; ();

	addrT addr;
	logic we;
	tagWordT wdata;

	// One registered read word per bank
	tagWordT rData [NumBanks];

	modport master (
		output addr, we, wdata
	);

	modport bank (
		input addr, we, wdata
	);

	modport monitor (
		input addr, rData
	);

endinterface

// ==== rtl/tagInitPkg.sv ====
package tagInitPkg;

	localparam int DataWidth = 16;
	localparam int PortTagWidth = 5;
	localparam int IdxFieldWidth = DataWidth - PortTagWidth;

	typedef logic [PortTagWidth-1:0] portTagT;

	// Port tags stamped into head and tail words
	localparam portTagT HeadTag = 5'b01010;
	localparam portTagT TailTag = 5'b01110;

	typedef struct packed {
		logic [IdxFieldWidth-1:0] blockIdx;
		portTagT portTag;
	} tagWordT;

	typedef enum logic [1:0] {
		SeqIdle,
		SeqWriting,
		SeqParked
	} seqStateT;

	function automatic tagWordT makeTag(logic [IdxFieldWidth-1:0] idx, portTagT tag);
		tagWordT word;
		word.blockIdx = idx;
		word.portTag = tag;
		return word;
	endfunction

endpackage

// ==== rtl/memMapPkg.sv ====
package memMapPkg;

	//////////////////////////////
	// Tag memory geometry
	//////////////////////////////
	localparam int AddrWidth = 15;
	localparam int BlockWords = 1024;
	localparam int NumBlocks = 32;
	localparam int NumBanks = 4;

	localparam int WordIdxWidth = $clog2(BlockWords);
	localparam int BlockIdxWidth = AddrWidth - WordIdxWidth;
	localparam int BlocksPerBank = NumBlocks / NumBanks;
	localparam int BankIdxWidth = $clog2(NumBanks);
	localparam int BankAddrWidth = AddrWidth - BankIdxWidth;

	typedef logic [AddrWidth-1:0] addrT;
	typedef logic [BlockIdxWidth-1:0] blockIdxT;
	typedef logic [BankIdxWidth-1:0] bankIdxT;

	//////////////////////////////
	// Address slicing
	//////////////////////////////
	function automatic bankIdxT bankOf(addrT addr);
		return addr[AddrWidth-1 -: BankIdxWidth];
	endfunction

	function automatic logic [BankAddrWidth-1:0] bankOffset(addrT addr);
		return addr[BankAddrWidth-1:0];
	endfunction

	// First and last word of a block
	function automatic addrT headAddr(blockIdxT blk);
		return {blk, {WordIdxWidth{1'b0}}};
	endfunction

	function automatic addrT tailAddr(blockIdxT blk);
		return {blk, {WordIdxWidth{1'b1}}};
	endfunction

endpackage
